// ==== compile.f ====
+incdir+verification
source/mips_pkg.sv
source/fetch_unit.sv
source/issue_control.sv
source/register_bank.sv
source/alu_pipe.sv
source/mem_pipe.sv
source/mul_pipe.sv
source/mips_core.sv
verification/tb_mips_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_mips_core -f compile.f -o tb_mips_core

./obj_dir/tb_mips_core | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation reported errors, see sim.log"
	exit 1
fi
exit 0

// ==== source/alu_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_pipe
(
	input logic clk,
	input logic rst,
	input logic i_go,
	input mips_pkg::alu_op_t i_alu_op,
	input logic [mips_pkg::XLEN-1:0] i_rs_data,
	input logic [mips_pkg::XLEN-1:0] i_rt_data,
	input logic [mips_pkg::XLEN-1:0] i_imm,
	input logic i_use_imm,
	input logic [mips_pkg::REG_ADDR_W-1:0] i_dest,
	output logic o_valid,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_reg,
	output logic [mips_pkg::XLEN-1:0] o_data
);

	logic [mips_pkg::XLEN-1:0] opb;
	logic [mips_pkg::XLEN-1:0] result;

	assign opb = i_use_imm ? i_imm : i_rt_data; // addi takes the immediate

	always_comb
	begin
		case (i_alu_op)
			mips_pkg::ALU_ADD: result = i_rs_data + opb;
			mips_pkg::ALU_SUB: result = i_rs_data - opb; // wraps modulo 2^32
			mips_pkg::ALU_AND: result = i_rs_data & opb;
			mips_pkg::ALU_SLT: result = {{(mips_pkg::XLEN-1){1'b0}}, i_rs_data < opb};
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			o_valid <= 1'b0;
		else
			o_valid <= i_go; // result port high in E+1
	end

	always_ff @(posedge clk)
	begin
		o_reg <= i_dest;
		o_data <= result;
	end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
(
	input logic clk,
	input logic rst,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic [mips_pkg::XLEN-1:0] o_wb_adr,
	input logic i_wb_ack,
	input logic [mips_pkg::XLEN-1:0] i_wb_dat,
	output logic [mips_pkg::XLEN-1:0] o_instr,
	output logic o_instr_valid,
	input logic i_instr_take
);

	mips_pkg::fetch_state_t state; // HOLD = buffer empty and bus idle
	logic [mips_pkg::XLEN-1:0] pc;
	logic [mips_pkg::XLEN-1:0] instr_buf; // one-entry buffer, payload only

	assign o_wb_cyc = (state == mips_pkg::FETCH_REQ); // cyc and stb move together
	assign o_wb_stb = (state == mips_pkg::FETCH_REQ);
	assign o_wb_adr = pc; // stable for the whole bus cycle
	assign o_instr = instr_buf;
	assign o_instr_valid = (state == mips_pkg::FETCH_FULL);

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= mips_pkg::FETCH_HOLD; // bus idle out of reset
			pc <= '0;
		end
		else
		begin
			case (state)
				mips_pkg::FETCH_HOLD:
				begin
					state <= mips_pkg::FETCH_REQ; // empty, so start a read
				end
				mips_pkg::FETCH_REQ:
				begin
					if (i_wb_ack)
					begin
						state <= mips_pkg::FETCH_FULL; // drops cyc/stb next cycle
						pc <= pc + 32'd4;
					end
				end
				mips_pkg::FETCH_FULL:
				begin
					if (i_instr_take)
						state <= mips_pkg::FETCH_HOLD; // empty from this edge
				end
				default:
				begin
					state <= mips_pkg::FETCH_HOLD;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == mips_pkg::FETCH_REQ && i_wb_ack)
			instr_buf <= i_wb_dat; // capture read data on ack
	end

endmodule

`default_nettype wire

// ==== source/issue_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_control
(
	input logic clk,
	input logic rst,
	input logic [mips_pkg::XLEN-1:0] i_instr,
	input logic i_instr_valid,
	output logic o_instr_take,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_rs_addr,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_rt_addr,
	output logic o_alu_go,
	output logic o_mem_go,
	output logic o_mul_go,
	output logic o_mem_store,
	output logic o_use_imm,
	output mips_pkg::alu_op_t o_alu_op,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_dest,
	output logic [mips_pkg::XLEN-1:0] o_imm,
	input logic i_wr_valid,
	input logic [mips_pkg::REG_ADDR_W-1:0] i_wr_reg
);

	mips_pkg::op_t op;
	mips_pkg::funct_t fn;
	logic [mips_pkg::REG_ADDR_W-1:0] rs, rt, rd;
	logic is_alu, is_mem, is_mul, is_nop, has_dest, uses_rt;
	logic hazard, ready, issue;
	logic [mips_pkg::NUM_REGS-1:0] pending; // writer in flight per register
	logic [mips_pkg::NUM_REGS-1:0] busy, wr_mask, dest_mask;
	logic [mips_pkg::SLOT_W-1:0] res; // bit i = result port taken i+1 cycles ahead
	logic [mips_pkg::SLOT_W-1:0] need; // slot the new instruction will use

	assign op = mips_pkg::op_t'(i_instr[31:26]);
	assign fn = mips_pkg::funct_t'(i_instr[5:0]);
	assign rs = i_instr[25:21];
	assign rt = i_instr[20:16];
	assign rd = i_instr[15:11];
	assign o_imm = {{(mips_pkg::XLEN-mips_pkg::IMM_W){1'b0}}, i_instr[mips_pkg::IMM_W-1:0]};
	assign o_rs_addr = rs;
	assign o_rt_addr = rt; // rt is also the store value

	always_comb
	begin
		is_alu = 1'b0;
		is_mem = 1'b0;
		is_mul = 1'b0;
		o_mem_store = 1'b0;
		o_use_imm = 1'b0;
		uses_rt = 1'b0;
		o_alu_op = mips_pkg::ALU_ADD;
		o_dest = rt; // i-type writes rt
		case (op)
			mips_pkg::OP_RTYPE:
			begin
				o_dest = rd;
				uses_rt = 1'b1;
				case (fn)
					mips_pkg::FN_ADD: is_alu = 1'b1;
					mips_pkg::FN_SUB:
					begin
						is_alu = 1'b1;
						o_alu_op = mips_pkg::ALU_SUB;
					end
					mips_pkg::FN_AND:
					begin
						is_alu = 1'b1;
						o_alu_op = mips_pkg::ALU_AND;
					end
					mips_pkg::FN_SLT:
					begin
						is_alu = 1'b1;
						o_alu_op = mips_pkg::ALU_SLT;
					end
					mips_pkg::FN_MUL: is_mul = 1'b1;
					default: ; // unknown funct, treated as nop
				endcase
			end
			mips_pkg::OP_ADDI:
			begin
				is_alu = 1'b1;
				o_use_imm = 1'b1;
			end
			mips_pkg::OP_LW: is_mem = 1'b1;
			mips_pkg::OP_SW:
			begin
				is_mem = 1'b1;
				o_mem_store = 1'b1;
				uses_rt = 1'b1;
			end
			default: ; // OP_NOP and unknown opcodes
		endcase
	end

	assign is_nop = !(is_alu || is_mem || is_mul);
	assign has_dest = !is_nop && !o_mem_store; // stores write no register

	always_comb
	begin
		wr_mask = '0;
		dest_mask = '0;
		need = '0;
		if (i_wr_valid)
			wr_mask[i_wr_reg] = 1'b1;
		if (issue && has_dest)
			dest_mask[o_dest] = 1'b1;
		if (has_dest && is_alu)
			need[mips_pkg::ALU_LAT-1] = 1'b1;
		if (has_dest && is_mem)
			need[mips_pkg::MEM_LAT-1] = 1'b1;
		if (is_mul)
			need[mips_pkg::MUL_LAT-1] = 1'b1;
	end

	// a register written this cycle is free, the bank bypasses it
	assign busy = pending & ~wr_mask;
	assign hazard = busy[rs] || (uses_rt && busy[rt]) || (has_dest && busy[o_dest]);
	assign ready = !hazard && ((res & need) == '0);
	assign issue = i_instr_valid && !is_nop && ready;

	assign o_instr_take = i_instr_valid && (is_nop || ready); // nops retire here
	assign o_alu_go = issue && is_alu;
	assign o_mem_go = issue && is_mem;
	assign o_mul_go = issue && is_mul;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			pending <= '0;
			res <= '0;
		end
		else
		begin
			pending <= (pending & ~wr_mask) | dest_mask; // new writer wins
			res <= (res | (issue ? need : '0)) >> 1; // shift every cycle
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_pipe
(
	input logic clk,
	input logic rst,
	input logic i_go,
	input logic i_store,
	input logic [mips_pkg::XLEN-1:0] i_rs_data,
	input logic [mips_pkg::XLEN-1:0] i_rt_data,
	input logic [mips_pkg::XLEN-1:0] i_imm,
	input logic [mips_pkg::REG_ADDR_W-1:0] i_dest,
	output logic o_valid,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_reg,
	output logic [mips_pkg::XLEN-1:0] o_data,
	output logic o_store_valid,
	output logic [$clog2(mips_pkg::DMEM_WORDS)-1:0] o_store_addr,
	output logic [mips_pkg::XLEN-1:0] o_store_data
);

	logic [mips_pkg::XLEN-1:0] dmem [mips_pkg::DMEM_WORDS];
	logic [mips_pkg::XLEN-1:0] ea; // effective address
	logic s1_valid, s1_store;
	logic [$clog2(mips_pkg::DMEM_WORDS)-1:0] s1_addr;
	logic [mips_pkg::REG_ADDR_W-1:0] s1_dest;
	logic [mips_pkg::XLEN-1:0] s1_wdata;

	assign ea = i_rs_data + i_imm;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			s1_valid <= 1'b0;
			o_valid <= 1'b0;
			o_store_valid <= 1'b0;
			for (int i = 0; i < mips_pkg::DMEM_WORDS; i++)
				dmem[i] <= i + 1; // data word i starts at i+1
		end
		else
		begin
			s1_valid <= i_go;
			o_valid <= s1_valid && !s1_store; // loads report as results
			o_store_valid <= s1_valid && s1_store; // stores pulse in E+2
			if (s1_valid && s1_store)
				dmem[s1_addr] <= s1_wdata;
		end
	end

	always_ff @(posedge clk)
	begin
		s1_store <= i_store; // stage one, address and operands
		s1_addr <= ea[$clog2(mips_pkg::DMEM_WORDS)-1:0]; // mod 32
		s1_dest <= i_dest;
		s1_wdata <= i_rt_data;
		o_reg <= s1_dest; // stage two, memory access
		o_data <= dmem[s1_addr];
		o_store_addr <= s1_addr;
		o_store_data <= s1_wdata;
	end

endmodule

`default_nettype wire

// ==== source/mips_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_core
(
	input logic clk,
	input logic rst,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic [mips_pkg::XLEN-1:0] o_wb_adr,
	input logic i_wb_ack,
	input logic [mips_pkg::XLEN-1:0] i_wb_dat,
	output logic o_ret_valid,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_ret_reg,
	output logic [mips_pkg::XLEN-1:0] o_ret_data,
	output logic o_store_valid,
	output logic [4:0] o_store_addr,
	output logic [mips_pkg::XLEN-1:0] o_store_data
);

	logic [mips_pkg::XLEN-1:0] instr;
	logic instr_valid, instr_take;
	logic [mips_pkg::REG_ADDR_W-1:0] rs_addr, rt_addr, dest, wr_reg;
	logic [mips_pkg::XLEN-1:0] rs_data, rt_data, imm;
	logic alu_go, mem_go, mul_go, mem_store, use_imm, wr_valid;
	mips_pkg::alu_op_t alu_op;
	logic alu_valid, mem_valid, mul_valid; // pipe result triples
	logic [mips_pkg::REG_ADDR_W-1:0] alu_reg, mem_reg, mul_reg;
	logic [mips_pkg::XLEN-1:0] alu_data, mem_data, mul_data;

	fetch_unit u_fetch
	(
		.clk(clk), .rst(rst),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
		.i_wb_ack(i_wb_ack), .i_wb_dat(i_wb_dat),
		.o_instr(instr), .o_instr_valid(instr_valid), .i_instr_take(instr_take)
	);

	issue_control u_issue
	(
		.clk(clk), .rst(rst),
		.i_instr(instr), .i_instr_valid(instr_valid), .o_instr_take(instr_take),
		.o_rs_addr(rs_addr), .o_rt_addr(rt_addr),
		.o_alu_go(alu_go), .o_mem_go(mem_go), .o_mul_go(mul_go),
		.o_mem_store(mem_store), .o_use_imm(use_imm), .o_alu_op(alu_op),
		.o_dest(dest), .o_imm(imm),
		.i_wr_valid(wr_valid), .i_wr_reg(wr_reg) // scoreboard release
	);

	register_bank u_regs
	(
		.clk(clk), .rst(rst),
		.i_rs_addr(rs_addr), .i_rt_addr(rt_addr),
		.o_rs_data(rs_data), .o_rt_data(rt_data),
		.i_alu_valid(alu_valid), .i_alu_reg(alu_reg), .i_alu_data(alu_data),
		.i_mem_valid(mem_valid), .i_mem_reg(mem_reg), .i_mem_data(mem_data),
		.i_mul_valid(mul_valid), .i_mul_reg(mul_reg), .i_mul_data(mul_data),
		.o_wr_valid(wr_valid), .o_wr_reg(wr_reg),
		.o_ret_valid(o_ret_valid), .o_ret_reg(o_ret_reg), .o_ret_data(o_ret_data)
	);

	alu_pipe u_alu
	(
		.clk(clk), .rst(rst), .i_go(alu_go), .i_alu_op(alu_op),
		.i_rs_data(rs_data), .i_rt_data(rt_data), .i_imm(imm), .i_use_imm(use_imm),
		.i_dest(dest), .o_valid(alu_valid), .o_reg(alu_reg), .o_data(alu_data)
	);

	mem_pipe u_mem
	(
		.clk(clk), .rst(rst), .i_go(mem_go), .i_store(mem_store),
		.i_rs_data(rs_data), .i_rt_data(rt_data), .i_imm(imm), .i_dest(dest),
		.o_valid(mem_valid), .o_reg(mem_reg), .o_data(mem_data),
		.o_store_valid(o_store_valid), .o_store_addr(o_store_addr),
		.o_store_data(o_store_data)
	);

	mul_pipe u_mul
	(
		.clk(clk), .rst(rst), .i_go(mul_go),
		.i_rs_data(rs_data), .i_rt_data(rt_data), .i_dest(dest),
		.o_valid(mul_valid), .o_reg(mul_reg), .o_data(mul_data)
	);

endmodule

`default_nettype wire

// ==== source/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	localparam int XLEN = 32; // data and address width
	localparam int REG_ADDR_W = 5; // register index
	localparam int NUM_REGS = 32;
	localparam int DMEM_WORDS = 32; // data memory depth
	localparam int IMM_W = 16; // immediate field

	localparam int ALU_LAT = 1; // issue to result, in cycles
	localparam int MEM_LAT = 2;
	localparam int MUL_LAT = 4;
	localparam int SLOT_W = MUL_LAT; // reservation covers the longest pipe

	typedef enum logic [5:0]
	{
		OP_NOP = 6'b000000,
		OP_RTYPE = 6'b000001,
		OP_ADDI = 6'b000101,
		OP_SW = 6'b001000,
		OP_LW = 6'b001001
	} op_t;

	// funct lives in the low six bits of an r-type word
	typedef enum logic [5:0]
	{
		FN_ADD = 6'd1,
		FN_SUB = 6'd2,
		FN_AND = 6'd4,
		FN_MUL = 6'd8,
		FN_SLT = 6'd16
	} funct_t;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_SLT} alu_op_t;

	typedef enum logic [1:0] {FETCH_REQ, FETCH_HOLD, FETCH_FULL} fetch_state_t;

endpackage

`default_nettype wire

// ==== source/mul_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_pipe
(
	input logic clk,
	input logic rst,
	input logic i_go,
	input logic [mips_pkg::XLEN-1:0] i_rs_data,
	input logic [mips_pkg::XLEN-1:0] i_rt_data,
	input logic [mips_pkg::REG_ADDR_W-1:0] i_dest,
	output logic o_valid,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_reg,
	output logic [mips_pkg::XLEN-1:0] o_data
);

	logic [mips_pkg::MUL_LAT-1:0] st_valid; // one item per stage
	logic [mips_pkg::REG_ADDR_W-1:0] st_reg [mips_pkg::MUL_LAT];
	logic [mips_pkg::XLEN-1:0] st_prod [mips_pkg::MUL_LAT];

	always_ff @(posedge clk)
	begin
		if (!rst)
			st_valid <= '0;
		else
			st_valid <= {st_valid[mips_pkg::MUL_LAT-2:0], i_go};
	end

	always_ff @(posedge clk)
	begin
		st_prod[0] <= i_rs_data * i_rt_data; // low 32 bits only
		st_reg[0] <= i_dest;
		for (int i = 1; i < mips_pkg::MUL_LAT; i++)
		begin
			st_prod[i] <= st_prod[i-1];
			st_reg[i] <= st_reg[i-1];
		end
	end

	assign o_valid = st_valid[mips_pkg::MUL_LAT-1]; // high in E+4
	assign o_reg = st_reg[mips_pkg::MUL_LAT-1];
	assign o_data = st_prod[mips_pkg::MUL_LAT-1];

endmodule

`default_nettype wire

// ==== source/register_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_bank
(
	input logic clk,
	input logic rst,
	input logic [mips_pkg::REG_ADDR_W-1:0] i_rs_addr,
	input logic [mips_pkg::REG_ADDR_W-1:0] i_rt_addr,
	output logic [mips_pkg::XLEN-1:0] o_rs_data,
	output logic [mips_pkg::XLEN-1:0] o_rt_data,
	input logic i_alu_valid,
	input logic [mips_pkg::REG_ADDR_W-1:0] i_alu_reg,
	input logic [mips_pkg::XLEN-1:0] i_alu_data,
	input logic i_mem_valid,
	input logic [mips_pkg::REG_ADDR_W-1:0] i_mem_reg,
	input logic [mips_pkg::XLEN-1:0] i_mem_data,
	input logic i_mul_valid,
	input logic [mips_pkg::REG_ADDR_W-1:0] i_mul_reg,
	input logic [mips_pkg::XLEN-1:0] i_mul_data,
	output logic o_wr_valid,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_wr_reg,
	output logic o_ret_valid,
	output logic [mips_pkg::REG_ADDR_W-1:0] o_ret_reg,
	output logic [mips_pkg::XLEN-1:0] o_ret_data
);

	logic [mips_pkg::XLEN-1:0] regs [mips_pkg::NUM_REGS];
	logic [mips_pkg::XLEN-1:0] wr_data;

	// reservation keeps at most one pipe valid per cycle
	assign o_wr_valid = i_alu_valid || i_mem_valid || i_mul_valid;
	assign o_wr_reg = i_alu_valid ? i_alu_reg : (i_mem_valid ? i_mem_reg : i_mul_reg);
	assign wr_data = i_alu_valid ? i_alu_data : (i_mem_valid ? i_mem_data : i_mul_data);

	// write-through bypass of the value landing this cycle
	assign o_rs_data = (o_wr_valid && i_rs_addr == o_wr_reg) ? wr_data : regs[i_rs_addr];
	assign o_rt_data = (o_wr_valid && i_rt_addr == o_wr_reg) ? wr_data : regs[i_rt_addr];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < mips_pkg::NUM_REGS; i++)
				regs[i] <= i; // register i starts at i
			o_ret_valid <= 1'b0;
		end
		else
		begin
			if (o_wr_valid)
				regs[o_wr_reg] <= wr_data; // r0 is an ordinary register
			o_ret_valid <= o_wr_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		o_ret_reg <= o_wr_reg; // retire report, one cycle after the write
		o_ret_data <= wr_data;
	end

endmodule

`default_nettype wire

// ==== verification/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef enum logic [2:0] {KIND_ALU, KIND_ADDI, KIND_LOAD, KIND_MUL, KIND_STORE} kind_t;

typedef struct packed
{
	kind_t kind; // which instruction class produced it
	logic [4:0] idx; // register, or data word for stores
	logic [31:0] data;
} exp_t;

logic [31:0] model_regs [32];
logic [31:0] model_mem [32];
exp_t wr_q [$]; // register writes in program order
exp_t st_q [$]; // stores in program order

function automatic string kind_name(input kind_t k);
	case (k)
		KIND_ALU: return "alu_result";
		KIND_ADDI: return "addi_result";
		KIND_LOAD: return "load_result";
		KIND_MUL: return "mul_result";
		default: return "store";
	endcase
endfunction

function automatic void model_reset();
	for (int i = 0; i < 32; i++)
	begin
		model_regs[i] = 32'(i); // register i holds i
		model_mem[i] = 32'(i + 1); // data word i holds i+1
	end
	wr_q.delete();
	st_q.delete();
endfunction

function automatic void push_write(input kind_t k, input logic [4:0] r, input logic [31:0] d);
	exp_t e;
	e.kind = k;
	e.idx = r;
	e.data = d;
	wr_q.push_back(e);
	model_regs[r] = d; // r0 is not hardwired
endfunction

// executes one word in order against the model state
function automatic void model_exec(input logic [31:0] w);
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rs, rt, rd;
	logic [31:0] a, b, imm, sum;
	exp_t e;
	op = w[31:26];
	fn = w[5:0];
	rs = w[25:21];
	rt = w[20:16];
	rd = w[15:11];
	a = model_regs[rs];
	b = model_regs[rt];
	imm = {16'd0, w[15:0]}; // zero-extended
	sum = a + imm;
	case (op)
		mips_pkg::OP_RTYPE:
		begin
			case (fn)
				mips_pkg::FN_ADD: push_write(KIND_ALU, rd, a + b);
				mips_pkg::FN_SUB: push_write(KIND_ALU, rd, a - b); // wraps
				mips_pkg::FN_AND: push_write(KIND_ALU, rd, a & b);
				mips_pkg::FN_SLT: push_write(KIND_ALU, rd, (a < b) ? 32'd1 : 32'd0); // unsigned
				mips_pkg::FN_MUL: push_write(KIND_MUL, rd, a * b); // low word
				default: ; // unknown funct does nothing
			endcase
		end
		mips_pkg::OP_ADDI: push_write(KIND_ADDI, rt, sum);
		mips_pkg::OP_LW: push_write(KIND_LOAD, rt, model_mem[sum[4:0]]); // mod 32
		mips_pkg::OP_SW:
		begin
			model_mem[sum[4:0]] = b;
			e.kind = KIND_STORE;
			e.idx = sum[4:0];
			e.data = b;
			st_q.push_back(e);
		end
		default: ; // nop and unknown opcodes
	endcase
endfunction

`endif

// ==== verification/tb_mips_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;

	logic clk;
	logic rst;
	logic wb_cyc, wb_stb, wb_ack;
	logic [31:0] wb_adr, wb_dat;
	logic ret_valid, store_valid;
	logic [4:0] ret_reg, store_addr;
	logic [31:0] ret_data, store_data;

	logic [31:0] lfsr_state;
	logic [31:0] prog [64]; // program image served from address 0
	logic [31:0] next_adr, req_adr;
	logic in_req, acked;
	int wait_left;
	int value_errors, protocol_errors, timeout_errors;

	`include "tb_model.svh"

	mips_core dut
	(
		.clk(clk), .rst(rst),
		.o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr),
		.i_wb_ack(wb_ack), .i_wb_dat(wb_dat),
		.o_ret_valid(ret_valid), .o_ret_reg(ret_reg), .o_ret_data(ret_data),
		.o_store_valid(store_valid), .o_store_addr(store_addr), .o_store_data(store_data)
	);

	always #10 clk = ~clk; // 20 ns period

	// fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'(32'd1 + take_bits(3) % 32'd7); // r1..r7 only
	endfunction

	function automatic logic [5:0] pick_funct();
		case (take_bits(3) % 32'd5)
			32'd0: return mips_pkg::FN_ADD;
			32'd1: return mips_pkg::FN_SUB;
			32'd2: return mips_pkg::FN_AND;
			32'd3: return mips_pkg::FN_MUL;
			default: return mips_pkg::FN_SLT;
		endcase
	endfunction

	function automatic logic [31:0] random_instr();
		logic [2:0] kind;
		logic [4:0] rs, rt, rd;
		logic [15:0] imm;
		logic [31:0] w;
		kind = 3'(take_bits(3));
		rs = pick_reg();
		rt = pick_reg();
		rd = pick_reg();
		imm = 16'(take_bits(16));
		case (kind)
			3'd0: w = 32'd0; // nop
			3'd1, 3'd2, 3'd3: w = {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, pick_funct()};
			3'd4, 3'd5: w = {mips_pkg::OP_ADDI, rs, rt, imm};
			3'd6: w = {mips_pkg::OP_LW, rs, rt, imm};
			default: w = {mips_pkg::OP_SW, rs, rt, imm};
		endcase
		return w;
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] adr);
		if (adr < 32'd256)
			return prog[adr[7:2]];
		return 32'd0; // nops after the program
	endfunction

	task automatic check_retire(input logic [4:0] r, input logic [31:0] d);
		int pos;
		pos = -1;
		for (int i = 0; i < wr_q.size(); i++)
			if (pos < 0 && wr_q[i].idx == r)
				pos = i; // oldest pending write to r
		assert (pos >= 0) else
		begin
			$display("retire to r%0d with value %h was not expected by the model", r, d);
			protocol_errors++;
		end
		if (pos >= 0)
		begin
			assert (d == wr_q[pos].data) else
			begin
				$display("[FAIL] %s r%0d: expected %h, actual %h",
					kind_name(wr_q[pos].kind), r, wr_q[pos].data, d);
				value_errors++;
			end
			wr_q.delete(pos);
		end
	endtask

	task automatic check_store(input logic [4:0] a, input logic [31:0] d);
		exp_t e;
		assert (st_q.size() > 0) else
		begin
			$display("store to word %0d with value %h was not expected by the model", a, d);
			protocol_errors++;
		end
		if (st_q.size() > 0)
		begin
			e = st_q.pop_front(); // stores leave in program order
			assert (a == e.idx) else
			begin
				$display("[FAIL] store_addr: expected %0d, actual %0d", e.idx, a);
				value_errors++;
			end
			assert (d == e.data) else
			begin
				$display("[FAIL] store_data: expected %h, actual %h", e.data, d);
				value_errors++;
			end
		end
	endtask

	// wishbone slave with 0 to 3 wait cycles per request
	always @(posedge clk)
	begin
		#2;
		if (!rst)
		begin
			wb_ack = 1'b0;
			in_req = 1'b0;
		end
		else if (wb_ack)
		begin
			wb_ack = 1'b0; // single-cycle ack
			in_req = 1'b0;
			assert (!wb_cyc) else
			begin
				$display("cyc stayed high in the cycle after an ack");
				protocol_errors++;
			end
		end
		else if (wb_cyc)
		begin
			assert (wb_stb) else
			begin
				$display("cyc high without stb");
				protocol_errors++;
			end
			if (!in_req)
			begin
				in_req = 1'b1;
				wait_left = int'(take_bits(2));
				assert (wb_adr == next_adr) else
				begin
					$display("[FAIL] fetch_address: expected %h, actual %h", next_adr, wb_adr);
					value_errors++;
				end
				req_adr = wb_adr;
				next_adr = next_adr + 32'd4; // sequential fetch
			end
			else
			begin
				assert (wb_adr == req_adr) else
				begin
					$display("fetch address changed while the request was waiting");
					protocol_errors++;
				end
			end
			if (wait_left == 0)
			begin
				wb_ack = 1'b1;
				wb_dat = fetch_word(wb_adr);
				acked = 1'b1;
			end
			else
				wait_left--;
		end
	end

	// registered outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (rst === 1'b1)
		begin
			if (!acked)
			begin
				assert (!ret_valid && !store_valid) else
				begin
					$display("retire or store pulse before the first instruction was fetched");
					protocol_errors++;
				end
			end
			if (ret_valid)
				check_retire(ret_reg, ret_data);
			if (store_valid)
				check_store(store_addr, store_data);
		end
	end

	initial
	begin
		int cycles;
		int drain;
		clk = 1'b0;
		rst = 1'b0;
		wb_ack = 1'b0;
		wb_dat = 32'd0;
		in_req = 1'b0;
		acked = 1'b0;
		wait_left = 0;
		next_adr = 32'd0; // first fetch at 0
		req_adr = 32'd0;
		value_errors = 0;
		protocol_errors = 0;
		timeout_errors = 0;
		lfsr_state = 32'h1ce;
		for (int i = 0; i < 64; i++)
			prog[i] = random_instr();
		model_reset();
		for (int i = 0; i < 64; i++)
			model_exec(prog[i]); // fills the expectation queues
		$display("program: %0d register writes, %0d stores", wr_q.size(), st_q.size());

		for (int i = 0; i < 8; i++)
		begin
			@(posedge clk);
			#2;
			assert (!wb_cyc && !ret_valid && !store_valid) else
			begin
				$display("bus or result strobe active during reset");
				protocol_errors++;
			end
			if (i == 7)
				rst = 1'b1; // release after 8 edges
		end

		cycles = 0;
		while ((wr_q.size() != 0 || st_q.size() != 0) && cycles < 4000)
		begin
			@(posedge clk);
			cycles++;
		end
		if (wr_q.size() != 0 || st_q.size() != 0)
		begin
			$display("timeout: %0d register writes and %0d stores never retired",
				wr_q.size(), st_q.size());
			timeout_errors++;
		end

		drain = 0;
		while (drain < 40)
		begin
			@(posedge clk); // catch stray retires on trailing nops
			drain++;
		end

		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors == 0 && protocol_errors == 0 && timeout_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
